//--- cnn_fused_params.svh
`ifndef CNN_FUSED_PARAMS_SVH
`define CNN_FUSED_PARAMS_SVH

// Feature word geometry
`define CNN_LANES       16    // Signed bytes per feature word

// Filter counts of the two layers
`define CNN_L1_FILTERS  16    // First-layer filters
`define CNN_L2_FILTERS  4     // Pointwise filters

// Store depths
`define CNN_IFM_DEPTH   256   // Input buffer words
`define CNN_WIN_MAX     16    // Longest window and weight bank depth

// Requantization
`define CNN_L1_SHIFT    4     // Layer one right shift
`define CNN_L2_SHIFT    6     // Layer two right shift
`define CNN_RELU6_MAX   96    // Six in Q4
`define CNN_INT8_MIN    -128  // Output saturation floor
`define CNN_INT8_MAX    127   // Output saturation ceiling

`endif

//--- cnn_fused_pkg.sv
`default_nettype none

`include "cnn_fused_params.svh"

package cnn_fused_pkg;

    typedef logic signed [7:0]            lane_t;       // One activation or weight
    typedef logic [8*`CNN_LANES-1:0]      feat_word_t;  // Lane i at bits 8i+7..8i
    typedef logic signed [31:0]           acc_t;        // Dot product accumulator
    typedef logic [7:0]                   ifm_addr_t;   // Input buffer address
    typedef logic [3:0]                   beat_t;       // Beat index or window length
    typedef logic [7:0]                   pix_cnt_t;    // Pixel count
    typedef logic [8*`CNN_L2_FILTERS-1:0] out_word_t;   // Four output lanes

    typedef enum logic [1:0] {
        LOAD_IFM,
        LOAD_W1,
        LOAD_W2
    } load_target_e;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_e;

    // Load port request
    typedef struct packed {
        logic         en;
        load_target_e target;
        logic [3:0]   bank;
        ifm_addr_t    addr;
        feat_word_t   data;
    } load_req_t;

    // Travels with each read beat
    typedef struct packed {
        logic valid;
        logic first;
        logic last_beat;  // Closes the pixel window
        logic last_pix;
    } beat_tag_t;

    typedef struct packed {
        logic      valid;
        logic      last;
        out_word_t data;
    } pix_result_t;

endpackage

`default_nettype wire

//--- cnn_fused_top.sv
`default_nettype none

`include "cnn_fused_params.svh"

module cnn_fused_top import cnn_fused_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire load_req_t load,
    input  wire logic      start,
    input  wire beat_t     win_len,
    input  wire pix_cnt_t  num_pix,
    output pix_result_t    result,
    output logic           busy
);

    logic       ifm_we;
    ifm_addr_t  ifm_addr;
    feat_word_t ifm_data;
    beat_t      beat;
    beat_tag_t  tag;
    feat_word_t w1 [`CNN_L1_FILTERS];
    acc_t       acc1 [`CNN_L1_FILTERS];
    logic       acc1_valid;
    logic       acc1_last;
    feat_word_t mid;
    logic       mid_valid;
    logic       mid_last;

    assign ifm_we = load.en && (load.target == LOAD_IFM);

    feature_ram #(
        .DEPTH (`CNN_IFM_DEPTH),
        .WIDTH ($bits(feat_word_t))
    ) u_ifm_buf (
        .clk     (clk),
        .we      (ifm_we),
        .wr_addr (load.addr),
        .wr_data (load.data),
        .rd_addr (ifm_addr),
        .rd_data (ifm_data)
    );

    conv_weight_banks u_w1_banks (
        .clk     (clk),
        .load    (load),
        .rd_addr (beat),
        .weights (w1)
    );

    window_sequencer u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .win_len  (win_len),
        .num_pix  (num_pix),
        .ifm_addr (ifm_addr),
        .beat     (beat),
        .tag      (tag),
        .busy     (busy)
    );

    pe_cluster #(
        .NUM_PE (`CNN_L1_FILTERS)
    ) u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .ifm       (ifm_data),
        .weights   (w1),
        .tag       (tag),
        .acc       (acc1),
        .acc_valid (acc1_valid),
        .acc_last  (acc1_last)
    );

    // ReLU6 in Q4 on the layer one sums
    requant_pack #(
        .NUM_CH (`CNN_L1_FILTERS),
        .SHIFT  (`CNN_L1_SHIFT),
        .LO     (0),
        .HI     (`CNN_RELU6_MAX)
    ) u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .acc          (acc1),
        .acc_valid    (acc1_valid),
        .acc_last     (acc1_last),
        .packed_data  (mid),
        .packed_valid (mid_valid),
        .packed_last  (mid_last)
    );

    pointwise_stage u_pointwise (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .mid       (mid),
        .mid_valid (mid_valid),
        .mid_last  (mid_last),
        .result    (result)
    );

endmodule

`default_nettype wire

//--- conv_weight_banks.sv
`default_nettype none

`include "cnn_fused_params.svh"

module conv_weight_banks import cnn_fused_pkg::*; (
    input  wire logic       clk,
    input  wire load_req_t  load,
    input  wire beat_t      rd_addr,
    output wire feat_word_t weights [`CNN_L1_FILTERS]
);

    logic [`CNN_L1_FILTERS-1:0] bank_we;
    beat_t                      wr_addr;

    assign wr_addr = load.addr[$bits(beat_t)-1:0];  // Beat index inside the window

    // One write enable per filter bank
    always_comb begin
        for (int b = 0; b < `CNN_L1_FILTERS; b++) begin
            bank_we[b] = load.en && (load.target == LOAD_W1) && (load.bank == 4'(b));
        end
    end

    // All banks read the same beat in parallel
    for (genvar b = 0; b < `CNN_L1_FILTERS; b++) begin : g_bank
        feature_ram #(
            .DEPTH (`CNN_WIN_MAX),
            .WIDTH ($bits(feat_word_t))
        ) u_bank (
            .clk     (clk),
            .we      (bank_we[b]),
            .wr_addr (wr_addr),
            .wr_data (load.data),
            .rd_addr (rd_addr),
            .rd_data (weights[b])
        );
    end

endmodule

`default_nettype wire

//--- feature_ram.sv
`default_nettype none

module feature_ram #(
    parameter int DEPTH = 256,
    parameter int WIDTH = 128
) (
    input  wire logic                     clk,
    input  wire logic                     we,
    input  wire logic [$clog2(DEPTH)-1:0] wr_addr,
    input  wire logic [WIDTH-1:0]         wr_data,
    input  wire logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [WIDTH-1:0]              rd_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];  // One cycle read latency
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
cnn_fused_pkg.sv
feature_ram.sv
conv_weight_banks.sv
window_sequencer.sv
pe_cluster.sv
requant_pack.sv
pointwise_stage.sv
cnn_fused_top.sv
tb_cnn_fused.sv

//--- pe_cluster.sv
`default_nettype none

`include "cnn_fused_params.svh"

module pe_cluster import cnn_fused_pkg::*; #(
    parameter int NUM_PE = 16
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire feat_word_t ifm,
    input  wire feat_word_t weights [NUM_PE],
    input  wire beat_tag_t  tag,
    output acc_t            acc [NUM_PE],
    output logic            acc_valid,
    output logic            acc_last
);

    acc_t prod [NUM_PE];

    // Sum of the signed lane products of one beat
    function automatic acc_t lane_dot(feat_word_t a, feat_word_t b);
        acc_t  sum;
        lane_t la;
        lane_t lb;
        sum = '0;
        for (int i = 0; i < `CNN_LANES; i++) begin
            la  = a[8*i +: 8];
            lb  = b[8*i +: 8];
            sum = sum + la * lb;
        end
        return sum;
    endfunction

    always_comb begin
        for (int p = 0; p < NUM_PE; p++) begin
            prod[p] = lane_dot(ifm, weights[p]);
        end
    end

    always_ff @(posedge clk) begin
        if (tag.valid) begin
            for (int p = 0; p < NUM_PE; p++) begin
                acc[p] <= tag.first ? prod[p] : acc[p] + prod[p];  // First beat restarts
            end
        end
    end

    // Window done one cycle after its last beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_valid <= 1'b0;
            acc_last  <= 1'b0;
        end else begin
            acc_valid <= tag.valid && tag.last_beat;
            acc_last  <= tag.valid && tag.last_beat && tag.last_pix;
        end
    end

endmodule

`default_nettype wire

//--- pointwise_stage.sv
`default_nettype none

`include "cnn_fused_params.svh"

module pointwise_stage import cnn_fused_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire load_req_t  load,
    input  wire feat_word_t mid,
    input  wire logic       mid_valid,
    input  wire logic       mid_last,
    output pix_result_t     result
);

    feat_word_t w2 [`CNN_L2_FILTERS];  // 1x1 filters, one word each
    feat_word_t mid_q;
    beat_tag_t  mid_tag;
    acc_t       acc2 [`CNN_L2_FILTERS];
    logic       acc2_valid;
    logic       acc2_last;
    out_word_t  out_data;
    logic       out_valid;
    logic       out_last;

    always_ff @(posedge clk) begin
        if (load.en && (load.target == LOAD_W2) && (load.bank < 4'(`CNN_L2_FILTERS))) begin
            w2[load.bank[1:0]] <= load.data;
        end
        mid_q <= mid;
    end

    // Every mid word is a window of one beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid_tag <= '0;
        end else begin
            mid_tag.valid     <= mid_valid;
            mid_tag.first     <= 1'b1;
            mid_tag.last_beat <= 1'b1;
            mid_tag.last_pix  <= mid_valid && mid_last;
        end
    end

    pe_cluster #(
        .NUM_PE (`CNN_L2_FILTERS)
    ) u_pe (
        .clk       (clk),
        .rst_n     (rst_n),
        .ifm       (mid_q),
        .weights   (w2),
        .tag       (mid_tag),
        .acc       (acc2),
        .acc_valid (acc2_valid),
        .acc_last  (acc2_last)
    );

    requant_pack #(
        .NUM_CH (`CNN_L2_FILTERS),
        .SHIFT  (`CNN_L2_SHIFT),
        .LO     (`CNN_INT8_MIN),
        .HI     (`CNN_INT8_MAX)
    ) u_requant (
        .clk          (clk),
        .rst_n        (rst_n),
        .acc          (acc2),
        .acc_valid    (acc2_valid),
        .acc_last     (acc2_last),
        .packed_data  (out_data),
        .packed_valid (out_valid),
        .packed_last  (out_last)
    );

    assign result = '{valid: out_valid, last: out_last, data: out_data};

endmodule

`default_nettype wire

//--- requant_pack.sv
`default_nettype none

module requant_pack import cnn_fused_pkg::*; #(
    parameter int NUM_CH = 16,
    parameter int SHIFT  = 4,
    parameter int LO     = 0,
    parameter int HI     = 96
) (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire acc_t           acc [NUM_CH],
    input  wire logic           acc_valid,
    input  wire logic           acc_last,
    output logic [8*NUM_CH-1:0] packed_data,
    output logic                packed_valid,
    output logic                packed_last
);

    logic [8*NUM_CH-1:0] lanes;

    function automatic lane_t sat_lane(acc_t v);
        acc_t s;
        s = v >>> SHIFT;  // Arithmetic shift keeps the sign
        if (s < LO) begin
            s = LO;
        end else if (s > HI) begin
            s = HI;
        end
        return s[7:0];
    endfunction

    always_comb begin
        for (int c = 0; c < NUM_CH; c++) begin
            lanes[8*c +: 8] = sat_lane(acc[c]);
        end
    end

    always_ff @(posedge clk) begin
        packed_data <= lanes;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            packed_valid <= 1'b0;
            packed_last  <= 1'b0;
        end else begin
            packed_valid <= acc_valid;
            packed_last  <= acc_valid && acc_last;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cnn_fused -f filelist.f -o sim_cnn_fused
if [ $? -ne 0 ]; then
    echo "Verilator build returned an error"
    exit 1
fi

output=$(./obj_dir/sim_cnn_fused)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

//--- tb_cnn_fused.sv
`default_nettype none

`include "cnn_fused_params.svh"

module tb_cnn_fused import cnn_fused_pkg::*; ();

    localparam int MODE_RANDOM   = 0;
    localparam int MODE_SMALL    = 1;
    localparam int MODE_POSITIVE = 2;
    localparam int MODE_NEGATIVE = 3;
    localparam int MODE_SATURATE = 4;
    localparam int NUM_CASES     = 8;

    typedef struct packed {
        int win;
        int num;
        int mode;
    } case_t;

    logic        clk;
    logic        rst_n;
    load_req_t   load;
    logic        start;
    beat_t       win_len;
    pix_cnt_t    num_pix;
    pix_result_t result;
    logic        busy;

    case_t       case_table [NUM_CASES];
    int          ifm_mem [`CNN_IFM_DEPTH][`CNN_LANES];               // Mirror of the input buffer
    int          w1_mem [`CNN_L1_FILTERS][`CNN_WIN_MAX][`CNN_LANES];  // Filter, beat, lane
    int          w2_mem [`CNN_L2_FILTERS][`CNN_LANES];
    logic [31:0] exp_q [$];
    logic [15:0] lfsr_state = 16'd53;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int          check_cnt = 0;
    int          error_cnt = 0;

    cnn_fused_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .start   (start),
        .win_len (win_len),
        .num_pix (num_pix),
        .result  (result),
        .busy    (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 16 14 13 11
    function logic take_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function int rand_val(int nbits, bit is_signed);
        int v;
        v = 0;
        for (int i = 0; i < nbits; i++) begin
            v = (v << 1) | int'(take_bit());
        end
        if (is_signed && v >= (1 << (nbits - 1))) begin
            v = v - (1 << nbits);
        end
        return v;
    endfunction

    function int gen_ifm(int mode);
        if (mode == MODE_RANDOM) return rand_val(5, 1'b1);
        if (mode == MODE_SMALL) return rand_val(3, 1'b1);
        return 64 + rand_val(6, 1'b0);  // Large positive activations
    endfunction

    function int gen_w1(int mode);
        if (mode == MODE_RANDOM) return rand_val(5, 1'b1);
        if (mode == MODE_SMALL) return rand_val(3, 1'b1);
        if (mode == MODE_NEGATIVE) return -1 - rand_val(7, 1'b0);  // -128 to -1
        return 64 + rand_val(6, 1'b0);
    endfunction

    function int gen_w2(int mode, int g);
        if (mode == MODE_SATURATE) return (g % 2 == 0) ? 127 : -128;
        if (mode == MODE_SMALL) return rand_val(3, 1'b1);
        return rand_val(5, 1'b1);
    endfunction

    function int clamp(int v, int lo, int hi);
        if (v < lo) return lo;
        if (v > hi) return hi;
        return v;
    endfunction

    task automatic load_word(load_target_e tgt, int bank, int addr, feat_word_t data);
        @(posedge clk);
        load <= '{en: 1'b1, target: tgt, bank: 4'(bank), addr: ifm_addr_t'(addr), data: data};
    endtask

    task automatic load_case(int win, int num, int mode);
        feat_word_t word;
        for (int a = 0; a < win * num; a++) begin
            for (int i = 0; i < `CNN_LANES; i++) begin
                ifm_mem[a][i]   = gen_ifm(mode);
                word[8*i +: 8] = 8'(ifm_mem[a][i]);
            end
            load_word(LOAD_IFM, 0, a, word);
        end
        for (int f = 0; f < `CNN_L1_FILTERS; f++) begin
            for (int k = 0; k < win; k++) begin
                for (int i = 0; i < `CNN_LANES; i++) begin
                    w1_mem[f][k][i] = gen_w1(mode);
                    word[8*i +: 8] = 8'(w1_mem[f][k][i]);
                end
                load_word(LOAD_W1, f, k, word);  // Address is the beat index
            end
        end
        for (int g = 0; g < `CNN_L2_FILTERS; g++) begin
            for (int i = 0; i < `CNN_LANES; i++) begin
                w2_mem[g][i]   = gen_w2(mode, g);
                word[8*i +: 8] = 8'(w2_mem[g][i]);
            end
            load_word(LOAD_W2, g, 0, word);
        end
        @(posedge clk);
        load.en <= 1'b0;
    endtask

    // Layer one with ReLU6 followed by the pointwise layer with int8 saturation
    task automatic build_expected(int win, int num);
        int          mid_lane [`CNN_L1_FILTERS];
        int          s;
        logic [31:0] word;
        for (int p = 0; p < num; p++) begin
            for (int f = 0; f < `CNN_L1_FILTERS; f++) begin
                s = 0;
                for (int k = 0; k < win; k++) begin
                    for (int i = 0; i < `CNN_LANES; i++) begin
                        s += ifm_mem[p * win + k][i] * w1_mem[f][k][i];
                    end
                end
                mid_lane[f] = clamp(s >>> `CNN_L1_SHIFT, 0, `CNN_RELU6_MAX);
            end
            for (int g = 0; g < `CNN_L2_FILTERS; g++) begin
                s = 0;
                for (int f = 0; f < `CNN_L1_FILTERS; f++) begin
                    s += mid_lane[f] * w2_mem[g][f];
                end
                word[8*g +: 8] = 8'(clamp(s >>> `CNN_L2_SHIFT, -128, 127));
            end
            exp_q.push_back(word);
        end
    endtask

    task automatic run_case(int idx);
        int          win;
        int          num;
        int          got;
        int          errs;
        int          wait_cnt;
        int          busy_cnt;
        logic [31:0] exp_word;
        win = case_table[idx].win;
        num = case_table[idx].num;
        errs = 0;
        load_case(win, num, case_table[idx].mode);
        build_expected(win, num);
        @(posedge clk);
        start   <= 1'b1;
        win_len <= beat_t'(win);
        num_pix <= pix_cnt_t'(num);
        @(posedge clk);
        start <= 1'b0;
        got = 0;
        wait_cnt = 0;
        busy_cnt = 0;
        while (got < num && wait_cnt < win * num + 20) begin
            @(posedge clk);
            wait_cnt++;
            if (busy === 1'b1) begin
                busy_cnt++;  // One beat issued per busy cycle
            end
            if (result.valid) begin
                exp_word = exp_q.pop_front();
                check_cnt++;
                if (result.data !== exp_word) begin
                    $display("Mismatch at %0t: result.data pixel %0d got %h expected %h",
                             $time, got, result.data, exp_word);
                    errs++;
                end
                if (result.last !== (got == num - 1)) begin
                    $display("Mismatch at %0t: result.last pixel %0d got %b expected %b",
                             $time, got, result.last, got == num - 1);
                    errs++;
                end
                got++;
            end
        end
        check_cnt++;
        if (busy_cnt != win * num) begin
            $display("Mismatch at %0t: busy high cycles got %0d expected %0d",
                     $time, busy_cnt, win * num);
            errs++;
        end
        if (got < num) begin
            $display("Only %0d of %0d outputs arrived in case %0d", got, num, idx);
            errs++;
        end
        for (int c = 0; c < win + 8; c++) begin
            @(posedge clk);
            if (result.valid) begin
                $display("Output beyond the last pixel at %0t in case %0d", $time, idx);
                errs++;
            end
        end
        if (busy) begin
            $display("busy still high after the run of case %0d", idx);
            errs++;
        end
        exp_q.delete();
        error_cnt += errs;
        $display("case %0d win_len %0d num_pix %0d mode %0d: %0d outputs, %0d errors",
                 idx, win, num, case_table[idx].mode, got, errs);
    endtask

    initial begin
        rst_n   = 1'b0;
        load    = '0;
        start   = 1'b0;
        win_len = 4'd1;
        num_pix = 8'd1;
        case_table[0] = '{win: 1, num: 1, mode: MODE_SMALL};
        case_table[1] = '{win: 4, num: 6, mode: MODE_RANDOM};
        case_table[2] = '{win: 15, num: 5, mode: MODE_RANDOM};
        case_table[3] = '{win: 3, num: 4, mode: MODE_NEGATIVE};
        case_table[4] = '{win: 5, num: 3, mode: MODE_POSITIVE};
        case_table[5] = '{win: 2, num: 4, mode: MODE_SATURATE};
        case_table[6] = '{win: 7, num: 8, mode: MODE_RANDOM};  // Reload with new weights
        case_table[7] = '{win: 1, num: 10, mode: MODE_RANDOM};
        // Run, load and idle cycles of every case, plus reset
        cycle_limit = 40;
        for (int c = 0; c < NUM_CASES; c++) begin
            cycle_limit += case_table[c].win * case_table[c].num + 20;
            cycle_limit += case_table[c].win * case_table[c].num
                           + 16 * case_table[c].win + 6;
            cycle_limit += case_table[c].win + 10;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            check_cnt++;
            if (result.valid || result.last || busy) begin
                $display("Mismatch at %0t: valid/last/busy got %b%b%b expected 000",
                         $time, result.valid, result.last, busy);
                error_cnt++;
            end
        end
        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(c);
        end
        $display("Cases %0d, checks %0d, errors %0d", NUM_CASES, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- window_sequencer.sv
`default_nettype none

module window_sequencer import cnn_fused_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     start,
    input  wire beat_t    win_len,
    input  wire pix_cnt_t num_pix,
    output ifm_addr_t     ifm_addr,
    output beat_t         beat,
    output beat_tag_t     tag,
    output logic          busy
);

    seq_state_e state;
    beat_t      beat_cnt;
    pix_cnt_t   pix_cnt;
    ifm_addr_t  addr_cnt;
    beat_t      win_len_q;   // Sizes held for the whole run
    pix_cnt_t   num_pix_q;
    logic       last_beat;
    logic       last_pix;

    assign last_beat = (beat_cnt == beat_t'(win_len_q - 4'd1));
    assign last_pix  = (pix_cnt == pix_cnt_t'(num_pix_q - 8'd1));
    assign busy      = (state == SEQ_RUN);
    assign ifm_addr  = addr_cnt;  // Pixel p, beat k reads p*win_len+k
    assign beat      = beat_cnt;  // Weight address

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SEQ_IDLE;
            beat_cnt  <= '0;
            pix_cnt   <= '0;
            addr_cnt  <= '0;
            win_len_q <= '0;
            num_pix_q <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        state     <= SEQ_RUN;
                        beat_cnt  <= '0;
                        pix_cnt   <= '0;
                        addr_cnt  <= '0;
                        win_len_q <= win_len;
                        num_pix_q <= num_pix;
                    end
                end
                SEQ_RUN: begin
                    addr_cnt <= addr_cnt + 8'd1;  // No gaps between pixels
                    if (last_beat) begin
                        beat_cnt <= '0;
                        pix_cnt  <= pix_cnt + 8'd1;
                        if (last_pix) begin
                            state <= SEQ_IDLE;
                        end
                    end else begin
                        beat_cnt <= beat_cnt + 4'd1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Tags lag the address by the memory read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag <= '0;
        end else begin
            tag.valid     <= busy;
            tag.first     <= busy && (beat_cnt == '0);
            tag.last_beat <= busy && last_beat;
            tag.last_pix  <= busy && last_beat && last_pix;
        end
    end

endmodule

`default_nettype wire
